//--- hdl/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // ========================================
    // geometry
    // ========================================

    // 3x3 window
    localparam int KX = 3;
    localparam int KY = 3;
    // input image size in pixels
    localparam int IMG_W = 8;
    localparam int IMG_H = 8;
    // output channels, one kernel engine each
    localparam int NUM_CO = 3;
    // taps per window
    localparam int WIN_N = KX * KY;

    // ========================================
    // data widths
    // ========================================

    // unsigned pixel
    localparam int PIX_W = 8;
    // signed weight
    localparam int WGT_W = 8;
    // nine products of 9b x 8b signed fit here
    localparam int ACC_W = 21;
    localparam int BIAS_W = 16;
    // unsigned saturated feature
    localparam int OUT_W = 16;

    // scalar types
    typedef logic [PIX_W-1:0] pix_t;
    typedef logic signed [WGT_W-1:0] wgt_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic signed [BIAS_W-1:0] bias_t;
    typedef logic [OUT_W-1:0] fmap_t;

    // row-major taps, tap 0 = oldest row leftmost column
    typedef pix_t [WIN_N-1:0] window_t;
    typedef wgt_t [WIN_N-1:0] kernel_wgt_t;
    // per channel parameter sets
    typedef kernel_wgt_t [NUM_CO-1:0] core_wgt_t;
    typedef bias_t [NUM_CO-1:0] core_bias_t;
    // kernel results gathered for the drain
    typedef acc_t [NUM_CO-1:0] acc_vec_t;
    // one output beat with every channel
    typedef fmap_t [NUM_CO-1:0] out_beat_t;

endpackage

`default_nettype wire

//--- hdl/line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module line_buffer
    import cnn_pkg::*;
(
    input  wire          clk,
    input  wire          reset_n,
    // pixel stream in raster order
    input  wire          i_in_valid,
    input  wire pix_t    i_in_pixel,
    output logic         o_in_ready,
    // window stream
    input  wire          i_win_ready,
    output logic         o_win_valid,
    output window_t      o_window
);

    // ========================================
    // position counters
    // ========================================

    // one spare bit so an overrun would be visible
    logic [$clog2(IMG_W):0] r_col;
    logic [$clog2(IMG_H):0] r_row;
    logic [$clog2(IMG_W)-1:0] w_col_idx;
    logic w_accept;
    logic w_full;
    logic r_win_valid;

    // row memories, a = previous row, b = the one before
    pix_t r_mem_a [IMG_W];
    pix_t r_mem_b [IMG_W];
    // last two columns of the window, per row
    pix_t r_sh [KY][KX-1];
    // new column, top row first
    pix_t w_col [KY];
    window_t w_next;

    // take a pixel while the window slot is empty or draining
    assign o_in_ready = !r_win_valid || i_win_ready;
    assign w_accept = i_in_valid && o_in_ready;
    assign w_col_idx = r_col[$clog2(IMG_W)-1:0];
    // window lies fully inside the image
    assign w_full = (r_col >= KX - 1) && (r_row >= KY - 1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_col <= '0;
            r_row <= '0;
        end else if (w_accept) begin
            if (r_col == IMG_W - 1) begin
                r_col <= '0;
                // wrap row too so frames run back to back
                if (r_row == IMG_H - 1) begin
                    r_row <= '0;
                end else begin
                    r_row <= r_row + 1'b1;
                end
            end else begin
                r_col <= r_col + 1'b1;
            end
        end
    end

    // ========================================
    // row memories and column shift
    // ========================================

    assign w_col[0] = r_mem_b[w_col_idx];
    assign w_col[1] = r_mem_a[w_col_idx];
    assign w_col[2] = i_in_pixel;

    always_ff @(posedge clk) begin
        if (w_accept) begin
            // row a ages into row b
            r_mem_b[w_col_idx] <= r_mem_a[w_col_idx];
            r_mem_a[w_col_idx] <= i_in_pixel;
            for (int ky = 0; ky < KY; ky++) begin
                for (int kx = 0; kx < KX - 2; kx++) begin
                    r_sh[ky][kx] <= r_sh[ky][kx+1];
                end
                r_sh[ky][KX-2] <= w_col[ky];
            end
        end
    end

    // stored columns on the left, new column on the right
    always_comb begin
        for (int ky = 0; ky < KY; ky++) begin
            for (int kx = 0; kx < KX - 1; kx++) begin
                w_next[ky*KX+kx] = r_sh[ky][kx];
            end
            w_next[ky*KX+KX-1] = w_col[ky];
        end
    end

    // ========================================
    // window register
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_win_valid <= 1'b0;
        end else if (w_accept && w_full) begin
            r_win_valid <= 1'b1;
        end else if (i_win_ready) begin
            r_win_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (w_accept && w_full) begin
            o_window <= w_next;
        end
    end

    assign o_win_valid = r_win_valid;

    // column counter wraps before it can index past a row
    a_col_range : assert property (@(posedge clk) disable iff (!reset_n)
        r_col < IMG_W);

endmodule

`default_nettype wire

//--- hdl/cnn_kernel.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_kernel
    import cnn_pkg::*;
(
    input  wire              clk,
    input  wire              reset_n,
    // static weights of this channel
    input  wire kernel_wgt_t i_weights,
    // window stream in
    input  wire              i_win_valid,
    input  wire window_t     i_window,
    output logic             o_win_ready,
    // sum stream out
    input  wire              i_ot_ready,
    output logic             o_ot_valid,
    output acc_t             o_ot_acc
);

    // ========================================
    // stage control
    // ========================================

    logic r_v1;
    logic r_v2;
    logic w_s1_ready;
    logic w_s2_ready;
    // zero-extended pixel times signed weight
    logic signed [PIX_W+WGT_W:0] r_prod [WIN_N];
    acc_t w_row_sum [KY];
    acc_t w_sum;

    // a stage takes data when empty or when it is being emptied
    assign w_s2_ready = !r_v2 || i_ot_ready;
    assign w_s1_ready = !r_v1 || w_s2_ready;
    assign o_win_ready = w_s1_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_v1 <= 1'b0;
            r_v2 <= 1'b0;
        end else begin
            if (w_s1_ready) begin
                r_v1 <= i_win_valid;
            end
            if (w_s2_ready) begin
                r_v2 <= r_v1;
            end
        end
    end

    // ========================================
    // stage 1 products
    // ========================================

    always_ff @(posedge clk) begin
        if (i_win_valid && w_s1_ready) begin
            for (int t = 0; t < WIN_N; t++) begin
                r_prod[t] <= $signed({1'b0, i_window[t]}) * $signed(i_weights[t]);
            end
        end
    end

    // ========================================
    // stage 2 adder tree
    // ========================================

    // per row partials first, then the three rows
    always_comb begin
        for (int ky = 0; ky < KY; ky++) begin
            w_row_sum[ky] = '0;
            for (int kx = 0; kx < KX; kx++) begin
                w_row_sum[ky] = w_row_sum[ky] + r_prod[ky*KX+kx];
            end
        end
        w_sum = w_row_sum[0] + w_row_sum[1] + w_row_sum[2];
    end

    always_ff @(posedge clk) begin
        if (r_v1 && w_s2_ready) begin
            o_ot_acc <= w_sum;
        end
    end

    assign o_ot_valid = r_v2;

    // held sum must not change until the drain takes it
    a_hold_acc : assert property (@(posedge clk) disable iff (!reset_n)
        (o_ot_valid && !i_ot_ready) |=> (o_ot_valid && $stable(o_ot_acc)));

endmodule

`default_nettype wire

//--- hdl/bias_relu.sv
`timescale 1ns/100ps
`default_nettype none

module bias_relu
    import cnn_pkg::*;
(
    input  wire               clk,
    input  wire               reset_n,
    // static per channel bias
    input  wire core_bias_t   i_bias,
    // sums from all kernels
    input  wire [NUM_CO-1:0]  i_acc_valid,
    input  wire acc_vec_t     i_acc,
    output logic              o_acc_ready,
    // output beat stream
    input  wire               i_ot_ready,
    output logic              o_ot_valid,
    output out_beat_t         o_ot_beat
);

    // ========================================
    // bias, relu, saturate
    // ========================================

    // one guard bit over the sum width
    logic signed [ACC_W:0] w_biased [NUM_CO];
    out_beat_t w_beat;
    logic r_valid;
    logic w_accept;

    always_comb begin
        for (int c = 0; c < NUM_CO; c++) begin
            // bias is sign-extended by the signed add
            w_biased[c] = $signed(i_acc[c]) + $signed(i_bias[c]);
            if (w_biased[c] < 0) begin
                // relu
                w_beat[c] = '0;
            end else if (w_biased[c] > (2 ** OUT_W - 1)) begin
                // clip at full scale
                w_beat[c] = '1;
            end else begin
                w_beat[c] = fmap_t'(w_biased[c][OUT_W-1:0]);
            end
        end
    end

    // ========================================
    // output register
    // ========================================

    // kernels run in lockstep so channel 0 speaks for all
    assign o_acc_ready = !r_valid || i_ot_ready;
    assign w_accept = i_acc_valid[0] && o_acc_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 1'b0;
        end else if (o_acc_ready) begin
            r_valid <= i_acc_valid[0];
        end
    end

    always_ff @(posedge clk) begin
        if (w_accept) begin
            o_ot_beat <= w_beat;
        end
    end

    assign o_ot_valid = r_valid;

    // kernel engines must never drift apart
    a_lockstep : assert property (@(posedge clk) disable iff (!reset_n)
        (i_acc_valid == '0) || (i_acc_valid == '1));

endmodule

`default_nettype wire

//--- hdl/cnn_core.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_core
    import cnn_pkg::*;
(
    input  wire              clk,
    input  wire              reset_n,
    // pixel stream
    input  wire              i_in_valid,
    input  wire pix_t        i_in_pixel,
    output logic             o_in_ready,
    // static layer parameters
    input  wire core_wgt_t   i_weights,
    input  wire core_bias_t  i_bias,
    // output feature stream
    output logic             o_ot_valid,
    output out_beat_t        o_ot_beat,
    input  wire              i_ot_ready
);

    // ========================================
    // window stream
    // ========================================

    logic w_win_valid;
    window_t w_window;
    // every kernel reports ready, channel 0 drives the line buffer
    logic [NUM_CO-1:0] w_win_ready;

    line_buffer u_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (i_in_valid),
        .i_in_pixel  (i_in_pixel),
        .o_in_ready  (o_in_ready),
        .i_win_ready (w_win_ready[0]),
        .o_win_valid (w_win_valid),
        .o_window    (w_window)
    );

    // ========================================
    // kernel engines
    // ========================================

    logic [NUM_CO-1:0] w_acc_valid;
    acc_vec_t w_acc;
    // shared ready keeps the engines in lockstep
    logic w_acc_ready;

    for (genvar c = 0; c < NUM_CO; c++) begin : gen_co_kernel
        cnn_kernel u_cnn_kernel (
            .clk         (clk),
            .reset_n     (reset_n),
            .i_weights   (i_weights[c]),
            .i_win_valid (w_win_valid),
            .i_window    (w_window),
            .o_win_ready (w_win_ready[c]),
            .i_ot_ready  (w_acc_ready),
            .o_ot_valid  (w_acc_valid[c]),
            .o_ot_acc    (w_acc[c])
        );
    end

    // ========================================
    // drain
    // ========================================

    bias_relu u_bias_relu (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_bias      (i_bias),
        .i_acc_valid (w_acc_valid),
        .i_acc       (w_acc),
        .o_acc_ready (w_acc_ready),
        .i_ot_ready  (i_ot_ready),
        .o_ot_valid  (o_ot_valid),
        .o_ot_beat   (o_ot_beat)
    );

endmodule

`default_nettype wire

//--- tb/tb_cnn_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cnn_core
    import cnn_pkg::*;
();

    // ========================================
    // vector file layout
    // ========================================

    localparam int CLK_NS = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_WGT = NUM_CO * WIN_N;
    localparam int N_PIX = 2 * IMG_W * IMG_H;
    localparam int N_EXP = 2 * (IMG_W - KX + 1) * (IMG_H - KY + 1);
    // word offsets inside the file
    localparam int BIAS_BASE = N_WGT;
    localparam int PIX_BASE = BIAS_BASE + NUM_CO;
    localparam int COUNT_IDX = PIX_BASE + N_PIX;
    localparam int EXP_BASE = COUNT_IDX + 1;
    localparam int N_WORDS = EXP_BASE + N_EXP;
    // quiet time before the final count
    localparam int QUIET_CYCLES = 20;
    // stall margin of 8 over one pixel per cycle
    localparam int WATCHDOG_NS = RESET_CYCLES * CLK_NS + N_PIX * CLK_NS * 8
        + QUIET_CYCLES * CLK_NS;
    localparam int LONG_STALL = 20;
    localparam int LONG_STALL_AT = 10;

    logic clk;
    logic reset_n;
    logic i_in_valid;
    pix_t i_in_pixel;
    logic o_in_ready;
    core_wgt_t i_weights;
    core_bias_t i_bias;
    logic o_ot_valid;
    out_beat_t o_ot_beat;
    logic i_ot_ready;

    logic [47:0] vec_mem [N_WORDS];
    int beat_count;
    int long_left;
    logic long_done;
    logic saw_in_ready_low;
    int seed_ret;

    cnn_core dut0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_pixel (i_in_pixel),
        .o_in_ready (o_in_ready),
        .i_weights  (i_weights),
        .i_bias     (i_bias),
        .o_ot_valid (o_ot_valid),
        .o_ot_beat  (o_ot_beat),
        .i_ot_ready (i_ot_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    // ========================================
    // compare tasks
    // ========================================

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_beat(input out_beat_t exp_beat, input out_beat_t act_beat);
        for (int c = 0; c < NUM_CO; c++) begin
            if (exp_beat[c] !== act_beat[c]) begin
                $display("[FAIL] %0t ns o_ot_beat[%0d] expected %h actual %h",
                    $time, c, exp_beat[c], act_beat[c]);
                stop_on_error();
            end
        end
    endtask

    task automatic check_count(input int exp_count, input int act_count);
        if (exp_count != act_count) begin
            $display("[FAIL] %0t ns beat_count expected %0d actual %0d",
                $time, exp_count, act_count);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
        if (exp_bit !== act_bit) begin
            $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp_bit, act_bit);
            stop_on_error();
        end
    endtask

    // raster pixel stream with random idle cycles
    task automatic send_pixels();
        for (int i = 0; i < N_PIX; i++) begin
            if (($urandom % 4) == 0) begin
                i_in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            i_in_valid = 1'b1;
            i_in_pixel = pix_t'(vec_mem[PIX_BASE + i][PIX_W-1:0]);
            // hold until accepted
            do begin
                @(posedge clk);
            end while (!o_in_ready);
            #1;
        end
        i_in_valid = 1'b0;
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        seed_ret = $urandom(32'he2120dcd);
        $readmemh("tb/cnn_vectors.txt", vec_mem);
        reset_n = 1'b0;
        i_in_valid = 1'b0;
        i_in_pixel = '0;
        i_ot_ready = 1'b0;
        // static parameters, channel major
        for (int c = 0; c < NUM_CO; c++) begin
            for (int t = 0; t < WIN_N; t++) begin
                i_weights[c][t] = wgt_t'(vec_mem[c * WIN_N + t][WGT_W-1:0]);
            end
            i_bias[c] = bias_t'(vec_mem[BIAS_BASE + c][BIAS_W-1:0]);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
        // idle state out of reset
        @(posedge clk);
        check_bit("o_ot_valid", 1'b0, o_ot_valid);
        check_bit("o_in_ready", 1'b1, o_in_ready);
        #1;
        send_pixels();
        wait (beat_count >= N_EXP);
        repeat (QUIET_CYCLES) @(posedge clk);
        check_count(int'(vec_mem[COUNT_IDX]), beat_count);
        // back-pressure reached the pixel input
        check_bit("o_in_ready low in long stall", 1'b1, saw_in_ready_low);
        $display("Testbench passed");
        $finish;
    end

    // ========================================
    // output sink
    // ========================================

    initial begin
        beat_count = 0;
        long_left = 0;
        long_done = 1'b0;
        saw_in_ready_low = 1'b0;
        wait (reset_n);
        forever begin
            @(posedge clk);
            if (o_ot_valid && i_ot_ready) begin
                // beats past the expected list are only counted
                if (beat_count < N_EXP) begin
                    check_beat(out_beat_t'(vec_mem[EXP_BASE + beat_count]), o_ot_beat);
                end
                beat_count++;
            end
            if (long_left > 0 && !o_in_ready) begin
                saw_in_ready_low = 1'b1;
            end
            #1;
            // one long stall, otherwise random gaps
            if (!long_done && beat_count == LONG_STALL_AT) begin
                long_done = 1'b1;
                long_left = LONG_STALL;
            end
            if (long_left > 0) begin
                i_ot_ready = 1'b0;
                long_left--;
            end else begin
                i_ot_ready = (($urandom % 4) != 0);
            end
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout, only %0d of %0d output beats arrived", beat_count, N_EXP);
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- tb/cnn_vectors.txt
// weights ch0..ch2 taps 0..8, biases ch0..ch2, 128 pixels, beat count,
// then expected beats {ch2, ch1, ch0} in raster window order
01 01 01 01 01 01 01 01 01
01 01 01 00 00 00 ff ff ff
7f 7f 7f 7f 7f 7f 7f 7f 7f
0005 000a fc18
// frame 1, pixel = 8*row + col
00 01 02 03 04 05 06 07
08 09 0a 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17
18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27
28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37
38 39 3a 3b 3c 3d 3e 3f
// frame 2, pixel = 255 - (8*row + col)
ff fe fd fc fb fa f9 f8
f7 f6 f5 f4 f3 f2 f1 f0
ef ee ed ec eb ea e9 e8
e7 e6 e5 e4 e3 e2 e1 e0
df de dd dc db da d9 d8
d7 d6 d5 d4 d3 d2 d1 d0
cf ce cd cc cb ca c9 c8
c7 c6 c5 c4 c3 c2 c1 c0
// beat count
48
// frame 1 beats
244700000056
28be0000005f
2d3500000068
31ac00000071
36230000007a
3a9a00000083
47ff0000009e
4c76000000a7
50ed000000b0
5564000000b9
59db000000c2
5e52000000cb
6bb7000000e6
702e000000ef
74a5000000f8
791c00000101
7d930000010a
820a00000113
8f6f0000012e
93e600000137
985d00000140
9cd400000149
a14b00000152
a5c20000015b
b32700000176
b79e0000017f
bc1500000188
c08c00000191
c5030000019a
c97a000001a3
d6df000001be
db56000001c7
dfcd000001d0
e444000001d9
e8bb000001e2
ed32000001eb
// frame 2 beats
ffff003a08ab
ffff003a08a2
ffff003a0899
ffff003a0890
ffff003a0887
ffff003a087e
ffff003a0863
ffff003a085a
ffff003a0851
ffff003a0848
ffff003a083f
ffff003a0836
ffff003a081b
ffff003a0812
ffff003a0809
ffff003a0800
ffff003a07f7
ffff003a07ee
ffff003a07d3
ffff003a07ca
ffff003a07c1
ffff003a07b8
ffff003a07af
ffff003a07a6
ffff003a078b
ffff003a0782
ffff003a0779
ffff003a0770
ffff003a0767
ffff003a075e
ffff003a0743
ffff003a073a
ffff003a0731
ffff003a0728
ffff003a071f
ffff003a0716

//--- compile.f
hdl/cnn_pkg.sv
hdl/line_buffer.sv
hdl/cnn_kernel.sv
hdl/bias_relu.sv
hdl/cnn_core.sv
tb/tb_cnn_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cnn_core testbench with Verilator.
# Run from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cnn_core \
    -Mdir obj_dir \
    -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_cnn_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Testbench passed"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi
